/* all.f */
hw/glb_pkg.sv
hw/glb_wr_ifc.sv
hw/glb_rd_ifc.sv
hw/glb_store_dma.sv
hw/glb_bank.sv
hw/glb_load_dma.sv
hw/glb_core.sv
testbench/tb_glb_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_glb_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, then check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_glb_core.sv */
`timescale 1ns/1ps

module tb_glb_core;

localparam int BANK_ADDR_WIDTH = 8;
// Index width and count of stream words in the whole bank
localparam int REF_IDX_W = BANK_ADDR_WIDTH + 2;
localparam int REF_WORDS = 2**REF_IDX_W;
localparam int WAIT_LIMIT = 2000;

logic                                clk;
logic                                clk_en;
logic                                rst_n;
logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_f2g;
logic                                stream_data_valid_f2g;
logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f;
logic                                stream_data_valid_g2f;
glb_pkg::dma_header_t                cfg_st_dma_header;
glb_pkg::dma_header_t                cfg_ld_dma_header;
logic                                st_start_pulse;
logic                                ld_start_pulse;
logic [1:0]                          interrupt_pulse;

integer seed;
// Expected contents with one entry per 16-bit lane
logic [glb_pkg::CGRA_DATA_WIDTH-1:0] ref_mem [REF_WORDS];

// Sequencer side
string       test_name;
int          test_errs;
int          err_count;
int          tests_run;
int          tests_failed;
int          mon_mark;
logic [15:0] ld_base;
int          ld_total;
int          words_base;

// Monitor side
int en_cyc = 0;
int words_seen = 0;
int st_done_cnt = 0;
int ld_done_cnt = 0;
int st_start_cyc = 0;
int ld_start_cyc = 0;
int st_done_cyc = 0;
int mon_errs = 0;
int mon_checks = 0;

glb_core #(
    .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
) UUT (
    .clk                    (clk),
    .clk_en                 (clk_en),
    .rst_n                  (rst_n),
    .stream_data_f2g        (stream_data_f2g),
    .stream_data_valid_f2g  (stream_data_valid_f2g),
    .stream_data_g2f        (stream_data_g2f),
    .stream_data_valid_g2f  (stream_data_valid_g2f),
    .cfg_st_dma_header      (cfg_st_dma_header),
    .cfg_ld_dma_header      (cfg_ld_dma_header),
    .st_start_pulse         (st_start_pulse),
    .ld_start_pulse         (ld_start_pulse),
    .interrupt_pulse        (interrupt_pulse)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Byte address to lane index modulo the bank size
function automatic logic [REF_IDX_W-1:0] ref_index(input logic [15:0] addr);
    return REF_IDX_W'(addr >> 1);
endfunction

function automatic logic [15:0] expected_word(input logic [15:0] addr);
    return ref_mem[ref_index(addr)];
endfunction

task automatic word_mismatch(input logic [15:0] exp_val, input logic [15:0] act_val);
    $display("ERR %s: expected %h, actual %h", test_name, exp_val, act_val);
    mon_errs++;
endtask

task automatic monitor_fault(input string what);
    $display("%s: %s", test_name, what);
    mon_errs++;
endtask

task automatic note_fault(input string what);
    $display("%s: %s", test_name, what);
    test_errs++;
endtask

// Output checker over enabled cycles only
always @(negedge clk) begin : monitor
    int          idx;
    logic [15:0] addr;
    if (rst_n && clk_en) begin
        idx = words_seen - words_base;
        addr = ld_base + 16'(2 * idx);
        if (st_start_pulse) begin
            st_start_cyc = en_cyc;
        end
        if (ld_start_pulse) begin
            ld_start_cyc = en_cyc;
        end
        if (interrupt_pulse[0]) begin
            st_done_cnt++;
            st_done_cyc = en_cyc;
        end
        // Load done goes with the last word or one cycle after an empty start
        if (interrupt_pulse[1]) begin
            ld_done_cnt++;
            mon_checks++;
            if (ld_total == 0 && (en_cyc != ld_start_cyc + 1 || stream_data_valid_g2f)) begin
                monitor_fault("empty load done pulse out of place");
            end
            if (ld_total != 0 && (!stream_data_valid_g2f || idx != ld_total - 1)) begin
                monitor_fault("load done pulse not on the last word");
            end
        end
        if (stream_data_valid_g2f) begin
            mon_checks++;
            if (idx >= ld_total) begin
                monitor_fault("output word with no load pending");
            end else begin
                // Word k shows up at start + 3 + k
                if (en_cyc != ld_start_cyc + 3 + idx) begin
                    monitor_fault("output word outside its expected cycle");
                end
                if (stream_data_g2f !== expected_word(addr)) begin
                    word_mismatch(expected_word(addr), stream_data_g2f);
                end
            end
            words_seen++;
        end
        en_cyc++;
    end
end

task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
    mon_mark = mon_errs;
endtask

task automatic finish_test();
    int errs;
    errs = test_errs + (mon_errs - mon_mark);
    err_count += test_errs;
    tests_run++;
    if (errs != 0) begin
        tests_failed++;
    end
    $display("test %0d %s: %s, %0d errors", tests_run, test_name,
             (errs == 0) ? "passed" : "failed", errs);
endtask

// Store n words from addr and then extra words the DMA must drop
task automatic store_run(input logic [15:0] addr, input int n, input int extra,
                         input bit gaps);
    int          s0;
    int          waited;
    logic [15:0] word;
    s0 = st_done_cnt;
    @(posedge clk);
    cfg_st_dma_header <= '{start_addr: addr, num_words: 16'(n)};
    st_start_pulse <= 1'b1;
    @(posedge clk);
    st_start_pulse <= 1'b0;
    for (int i = 0; i < n + extra; i++) begin
        if (gaps) begin
            repeat ($unsigned($random(seed)) % 3) begin
                @(posedge clk);
                stream_data_valid_f2g <= 1'b0;
            end
        end
        @(posedge clk);
        word = 16'($random(seed));
        stream_data_valid_f2g <= 1'b1;
        stream_data_f2g <= word;
        if (i < n) begin
            ref_mem[ref_index(addr + 16'(2 * i))] = word;
        end
    end
    @(posedge clk);
    stream_data_valid_f2g <= 1'b0;
    waited = 0;
    while (st_done_cnt == s0 && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
    end
    if (st_done_cnt == s0) begin
        note_fault("timeout waiting for store done");
    end
    repeat (4) @(posedge clk);
    if (st_done_cnt != s0 + 1) begin
        note_fault("store done not seen exactly once");
    end
    if (n == 0 && st_done_cyc != st_start_cyc + 1) begin
        note_fault("empty store done pulse not one cycle after start");
    end
endtask

// Load n words with an optional clk_en drop of hold_len cycles
task automatic load_run(input logic [15:0] addr, input int n, input int hold_at,
                        input int hold_len);
    int d0;
    int s0;
    int waited;
    d0 = ld_done_cnt;
    s0 = st_done_cnt;
    ld_base = {addr[15:1], 1'b0};
    ld_total = n;
    words_base = words_seen;
    @(posedge clk);
    cfg_ld_dma_header <= '{start_addr: addr, num_words: 16'(n)};
    ld_start_pulse <= 1'b1;
    @(posedge clk);
    ld_start_pulse <= 1'b0;
    waited = 0;
    while (ld_done_cnt == d0 && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
        // Stall the whole core mid-stream
        if (waited == hold_at) begin
            clk_en <= 1'b0;
        end
        if (waited == hold_at + hold_len) begin
            clk_en <= 1'b1;
        end
    end
    clk_en <= 1'b1;
    if (ld_done_cnt == d0) begin
        note_fault("timeout waiting for load done");
    end
    repeat (4) @(posedge clk);
    if (words_seen - words_base != n) begin
        note_fault("load returned the wrong number of words");
    end
    if (ld_done_cnt != d0 + 1) begin
        note_fault("load done not seen exactly once");
    end
    if (st_done_cnt != s0) begin
        note_fault("store done pulsed during a load");
    end
endtask

initial begin
    seed = 32'h7d21;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    ld_base = '0;
    ld_total = 0;
    words_base = 0;
    clk_en <= 1'b1;
    rst_n <= 1'b0;
    stream_data_f2g <= '0;
    stream_data_valid_f2g <= 1'b0;
    cfg_st_dma_header <= '0;
    cfg_ld_dma_header <= '0;
    st_start_pulse <= 1'b0;
    ld_start_pulse <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("round_trip");
    @(negedge clk);
    if (stream_data_valid_g2f !== 1'b0 || interrupt_pulse !== 2'b00) begin
        note_fault("outputs not idle after reset");
    end
    store_run(16'h0100, 32, 0, 1'b0);
    load_run(16'h0100, 32, 0, 0);
    finish_test();

    // Lanes 3.. of word 0x20 onward
    // Neighbors from the round trip stay
    begin_test("unaligned_neighbors");
    store_run(16'h0106, 5, 0, 1'b0);
    load_run(16'h0100, 12, 0, 0);
    finish_test();

    begin_test("gaps_and_extra_words");
    store_run(16'h0122, 6, 4, 1'b1);
    load_run(16'h0120, 8, 0, 0);
    finish_test();

    // Cycle placement is checked by the monitor on every load
    begin_test("load_timing");
    load_run(16'h0104, 10, 0, 0);
    finish_test();

    // Stray words after an empty store would land in the range loaded below
    begin_test("zero_length_and_clk_en");
    store_run(16'h0100, 0, 2, 1'b0);
    load_run(16'h0200, 0, 0, 0);
    load_run(16'h0100, 32, 5, 6);
    finish_test();

    err_count += mon_errs;
    $display("summary: %0d tests, %0d failed, %0d word checks, %0d errors",
             tests_run, tests_failed, mon_checks, err_count);
    if (err_count == 0 && tests_failed == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

/* hw/glb_core.sv */
`timescale 1ns/1ps

module glb_core #(
    parameter int BANK_ADDR_WIDTH = 8
) (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                rst_n,

    // Fabric stream in
    input  logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                                stream_data_valid_f2g,

    // Fabric stream out
    output logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                stream_data_valid_g2f,

    // DMA headers
    input  glb_pkg::dma_header_t                cfg_st_dma_header,
    input  glb_pkg::dma_header_t                cfg_ld_dma_header,

    // DMA kick-off
    input  logic                                st_start_pulse,
    input  logic                                ld_start_pulse,

    // Bit 0 store done, bit 1 load done
    output logic [1:0]                          interrupt_pulse
);

logic st_done_pulse;
logic ld_done_pulse;

// Bank ports
glb_wr_ifc #(.BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)) wr_if ();
glb_rd_ifc #(.BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)) rd_if ();

// Fabric to bank
glb_store_dma #(
    .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
) store_dma (
    .clk                    (clk),
    .clk_en                 (clk_en),
    .rst_n                  (rst_n),
    .cfg_st_dma_header      (cfg_st_dma_header),
    .st_start_pulse         (st_start_pulse),
    .stream_data_valid_f2g  (stream_data_valid_f2g),
    .stream_data_f2g        (stream_data_f2g),
    .st_done_pulse          (st_done_pulse),
    .wr_if                  (wr_if)
);

// Storage
glb_bank #(
    .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
) bank (
    .clk    (clk),
    .clk_en (clk_en),
    .rst_n  (rst_n),
    .wr_if  (wr_if),
    .rd_if  (rd_if)
);

// Bank to fabric
glb_load_dma #(
    .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
) load_dma (
    .clk                    (clk),
    .clk_en                 (clk_en),
    .rst_n                  (rst_n),
    .cfg_ld_dma_header      (cfg_ld_dma_header),
    .ld_start_pulse         (ld_start_pulse),
    .rd_if                  (rd_if),
    .stream_data_g2f        (stream_data_g2f),
    .stream_data_valid_g2f  (stream_data_valid_g2f),
    .ld_done_pulse          (ld_done_pulse)
);

assign interrupt_pulse = {ld_done_pulse, st_done_pulse};

endmodule

/* hw/glb_load_dma.sv */
`timescale 1ns/1ps

module glb_load_dma #(
    parameter int BANK_ADDR_WIDTH = 8
) (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                rst_n,
    input  glb_pkg::dma_header_t                cfg_ld_dma_header,
    input  logic                                ld_start_pulse,
    glb_rd_ifc.consumer                         rd_if,
    output logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                stream_data_valid_g2f,
    output logic                                ld_done_pulse
);

logic                                 busy;
logic [glb_pkg::GLB_ADDR_WIDTH-1:0]   cur_addr;
logic [glb_pkg::DMA_CNT_WIDTH-1:0]    rd_remaining;
logic [glb_pkg::DMA_CNT_WIDTH-1:0]    out_remaining;
logic [glb_pkg::LANE_SEL_WIDTH-1:0]   rd_lane_q;
logic [glb_pkg::CGRA_DATA_WIDTH-1:0]  lane_data;

// Bank word of the read being issued
assign rd_if.rd_addr =
    cur_addr[BANK_ADDR_WIDTH+glb_pkg::BANK_BYTE_OFFSET-1:glb_pkg::BANK_BYTE_OFFSET];

// Lane select travels with the read, ready when the data returns
always_ff @(posedge clk) begin
    if (clk_en && rd_if.rd_en) begin
        rd_lane_q <= cur_addr[glb_pkg::BANK_BYTE_OFFSET-1 -: glb_pkg::LANE_SEL_WIDTH];
    end
end

// Pick the 16-bit lane out of the returned bank word
always_comb begin
    lane_data = '0;
    for (int i = 0; i < glb_pkg::BANK_LANES; i++) begin
        if (rd_lane_q == i[glb_pkg::LANE_SEL_WIDTH-1:0]) begin
            lane_data = rd_if.rd_data[i*glb_pkg::CGRA_DATA_WIDTH +: glb_pkg::CGRA_DATA_WIDTH];
        end
    end
end

// Read issue, output valid and done
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy                  <= 1'b0;
        cur_addr              <= '0;
        rd_remaining          <= '0;
        out_remaining         <= '0;
        rd_if.rd_en           <= 1'b0;
        stream_data_valid_g2f <= 1'b0;
        ld_done_pulse         <= 1'b0;
    end else if (clk_en) begin
        // Output stage follows the bank valid
        stream_data_valid_g2f <= rd_if.rd_data_valid;
        ld_done_pulse         <= 1'b0;
        if (!busy && ld_start_pulse) begin
            cur_addr      <= {cfg_ld_dma_header.start_addr[glb_pkg::GLB_ADDR_WIDTH-1:1], 1'b0};
            rd_remaining  <= cfg_ld_dma_header.num_words;
            out_remaining <= cfg_ld_dma_header.num_words;
            rd_if.rd_en   <= (cfg_ld_dma_header.num_words != '0);
            busy          <= (cfg_ld_dma_header.num_words != '0);
            // Nothing to read, finish next cycle
            ld_done_pulse <= (cfg_ld_dma_header.num_words == '0);
        end else begin
            // One read per cycle until all are issued
            if (rd_if.rd_en) begin
                cur_addr     <= cur_addr + glb_pkg::STRM_ADDR_STEP;
                rd_remaining <= rd_remaining - 1;
                rd_if.rd_en  <= (rd_remaining != 1);
            end
            // Count returned words, done with the last one
            if (rd_if.rd_data_valid) begin
                out_remaining <= out_remaining - 1;
                if (out_remaining == 1) begin
                    busy          <= 1'b0;
                    ld_done_pulse <= 1'b1;
                end
            end
        end
    end
end

// Output word register
always_ff @(posedge clk) begin
    if (clk_en && rd_if.rd_data_valid) begin
        stream_data_g2f <= lane_data;
    end
end

endmodule

/* hw/glb_bank.sv */
`timescale 1ns/1ps

module glb_bank #(
    parameter int BANK_ADDR_WIDTH = 8
) (
    input  logic       clk,
    input  logic       clk_en,
    input  logic       rst_n,
    glb_wr_ifc.bank    wr_if,
    glb_rd_ifc.bank    rd_if
);

// Bits per strobe
localparam int BYTE_WIDTH = glb_pkg::BANK_DATA_WIDTH / glb_pkg::BANK_STRB_WIDTH;

// Storage
logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

// Byte-strobed write
always_ff @(posedge clk) begin
    if (clk_en && wr_if.wr_en) begin
        for (int b = 0; b < glb_pkg::BANK_STRB_WIDTH; b++) begin
            if (wr_if.wr_strb[b]) begin
                mem[wr_if.wr_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                    wr_if.wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end
    end
end

// Registered read
// Same-cycle write to the same word is not visible here yet
always_ff @(posedge clk) begin
    if (clk_en && rd_if.rd_en) begin
        rd_if.rd_data <= mem[rd_if.rd_addr];
    end
end

// Valid trails rd_en by one enabled cycle
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rd_if.rd_data_valid <= 1'b0;
    end else if (clk_en) begin
        rd_if.rd_data_valid <= rd_if.rd_en;
    end
end

endmodule

/* hw/glb_store_dma.sv */
`timescale 1ns/1ps

module glb_store_dma #(
    parameter int BANK_ADDR_WIDTH = 8
) (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                rst_n,
    input  glb_pkg::dma_header_t                cfg_st_dma_header,
    input  logic                                st_start_pulse,
    input  logic                                stream_data_valid_f2g,
    input  logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_f2g,
    output logic                                st_done_pulse,
    glb_wr_ifc.producer                         wr_if
);

logic                                 busy;
logic [glb_pkg::GLB_ADDR_WIDTH-1:0]   cur_addr;
logic [glb_pkg::DMA_CNT_WIDTH-1:0]    remaining;
logic                                 accept;
logic [glb_pkg::LANE_SEL_WIDTH-1:0]   cur_lane;
logic [glb_pkg::BANK_DATA_WIDTH-1:0]  wr_data_next;
logic [glb_pkg::BANK_STRB_WIDTH-1:0]  wr_strb_next;

// Words only count while a transfer is open
assign accept = busy && stream_data_valid_f2g;

// 16-bit lane inside the bank word
assign cur_lane = cur_addr[glb_pkg::BANK_BYTE_OFFSET-1 -: glb_pkg::LANE_SEL_WIDTH];

// Steer the word and its two strobes into the addressed lane
always_comb begin
    wr_data_next = '0;
    wr_strb_next = '0;
    for (int i = 0; i < glb_pkg::BANK_LANES; i++) begin
        if (cur_lane == i[glb_pkg::LANE_SEL_WIDTH-1:0]) begin
            wr_data_next[i*glb_pkg::CGRA_DATA_WIDTH +: glb_pkg::CGRA_DATA_WIDTH] =
                stream_data_f2g;
            wr_strb_next[i*glb_pkg::CGRA_STRB_WIDTH +: glb_pkg::CGRA_STRB_WIDTH] = '1;
        end
    end
end

// Transfer control, write enable and done
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy          <= 1'b0;
        cur_addr      <= '0;
        remaining     <= '0;
        wr_if.wr_en   <= 1'b0;
        st_done_pulse <= 1'b0;
    end else if (clk_en) begin
        // One write per accepted word, one cycle later
        wr_if.wr_en   <= accept;
        st_done_pulse <= 1'b0;
        if (!busy && st_start_pulse) begin
            cur_addr  <= {cfg_st_dma_header.start_addr[glb_pkg::GLB_ADDR_WIDTH-1:1], 1'b0};
            remaining <= cfg_st_dma_header.num_words;
            busy      <= (cfg_st_dma_header.num_words != '0);
            // Empty transfer finishes right away
            st_done_pulse <= (cfg_st_dma_header.num_words == '0);
        end else if (accept) begin
            cur_addr  <= cur_addr + glb_pkg::STRM_ADDR_STEP;
            remaining <= remaining - 1;
            // Last word, done lines up with its write
            if (remaining == 1) begin
                busy          <= 1'b0;
                st_done_pulse <= 1'b1;
            end
        end
    end
end

// Write payload
always_ff @(posedge clk) begin
    if (clk_en && accept) begin
        wr_if.wr_addr <=
            cur_addr[BANK_ADDR_WIDTH+glb_pkg::BANK_BYTE_OFFSET-1:glb_pkg::BANK_BYTE_OFFSET];
        wr_if.wr_data <= wr_data_next;
        wr_if.wr_strb <= wr_strb_next;
    end
end

endmodule

/* hw/glb_rd_ifc.sv */
`timescale 1ns/1ps

// Bank read port
// Data and valid come back one enabled cycle after rd_en
interface glb_rd_ifc #(
    parameter int BANK_ADDR_WIDTH = 8
) ();

logic                                 rd_en;
logic [BANK_ADDR_WIDTH-1:0]           rd_addr;
logic [glb_pkg::BANK_DATA_WIDTH-1:0]  rd_data;
logic                                 rd_data_valid;

// Load DMA side
modport consumer (
    output rd_en, rd_addr,
    input  rd_data, rd_data_valid
);

// Memory side
modport bank (
    input  rd_en, rd_addr,
    output rd_data, rd_data_valid
);

endinterface

/* hw/glb_wr_ifc.sv */
`timescale 1ns/1ps

// Bank write port
// One write per cycle with wr_en high, only strobed bytes change
interface glb_wr_ifc #(
    parameter int BANK_ADDR_WIDTH = 8
) ();

logic                                 wr_en;
logic [glb_pkg::BANK_STRB_WIDTH-1:0]  wr_strb;
logic [BANK_ADDR_WIDTH-1:0]           wr_addr;
logic [glb_pkg::BANK_DATA_WIDTH-1:0]  wr_data;

// Store DMA side
modport producer (
    output wr_en, wr_strb, wr_addr, wr_data
);

// Memory side
modport bank (
    input  wr_en, wr_strb, wr_addr, wr_data
);

endinterface

/* hw/glb_pkg.sv */
package glb_pkg;

// Fabric stream word
localparam int CGRA_DATA_WIDTH = 16;

// Bank word and its byte strobes
localparam int BANK_DATA_WIDTH = 64;
localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;

// Byte address carried in a DMA header
localparam int GLB_ADDR_WIDTH = 16;

// Stream word count carried in a DMA header
localparam int DMA_CNT_WIDTH = 16;

// Bytes covered by one stream word
localparam int CGRA_STRB_WIDTH = CGRA_DATA_WIDTH / 8;

// Stream lanes packed in one bank word
localparam int BANK_LANES = BANK_DATA_WIDTH / CGRA_DATA_WIDTH;
localparam int LANE_SEL_WIDTH = $clog2(BANK_LANES);

// Low byte address bits that sit inside one bank word
localparam int BANK_BYTE_OFFSET = $clog2(BANK_STRB_WIDTH);

// Byte address step between consecutive stream words
localparam logic [GLB_ADDR_WIDTH-1:0] STRM_ADDR_STEP = GLB_ADDR_WIDTH'(CGRA_STRB_WIDTH);

// DMA header
// start_addr bit 0 is ignored, so transfers stay 16-bit aligned
typedef struct packed {
    logic [GLB_ADDR_WIDTH-1:0] start_addr;
    logic [DMA_CNT_WIDTH-1:0]  num_words;
} dma_header_t;

endpackage
